//--- dv/tb_testharness.sv
//////////////////////////////////////////////////////////////////////
// Harness testbench with clock, reset, random register, gpio and
// power switch stimulus, reference model and compare tasks
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_testharness;

  localparam int unsigned WAIT_MAX = 20;
  localparam int unsigned NP = harness_pkg::EXT_NPERIPH;

  logic                     clk_i;
  logic                     rst_i;
  harness_pkg::reg_req_t    reg_req;
  harness_pkg::reg_rsp_t    reg_rsp;
  logic [NP-1:0]            gpio;
  harness_pkg::intr_vec_t   intr;
  harness_pkg::pwr_switch_t sw_n;
  harness_pkg::pwr_switch_t ack_n;

  // Reference model
  logic [31:0]              mdl_count[NP];
  logic [31:0]              mdl_thresh[NP];
  harness_pkg::intr_vec_t   mdl_flag;
  harness_pkg::pwr_switch_t sw_hist[$];

  logic [31:0] lcg_state;
  int          errors;
  int          tests_ok;
  int          tests_bad;

  testharness_top dut0 (
    .clk_i,
    .rst_i,
    .reg_req_i         (reg_req),
    .reg_rsp_o         (reg_rsp),
    .gpio_i            (gpio),
    .intr_o            (intr),
    .pwr_switch_n_i    (sw_n),
    .pwr_switch_ack_n_o(ack_n)
  );

  always #10 clk_i = ~clk_i;

  // Upper state bits are the better random ones
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  function automatic logic [31:0] slot_addr(input int slot, input logic [31:0] off);
    return harness_pkg::PERIPH_BASE + 32'(slot) * harness_pkg::PERIPH_SLOT_SIZE + off;
  endfunction

  function automatic harness_pkg::reg_rsp_t rsp_ok(input logic [31:0] rdata);
    return '{ready: 1'b1, error: 1'b0, rdata: rdata};
  endfunction

  // One detected rise on counter s
  function automatic void model_rise(input int s);
    if (mdl_count[s] + 32'd1 == mdl_thresh[s]) begin
      mdl_count[s] = '0;
      mdl_flag[s]  = 1'b1;
    end else begin
      mdl_count[s] = mdl_count[s] + 32'd1;
    end
  endfunction

  task automatic check_rsp(input string name, input harness_pkg::reg_rsp_t got,
                           input harness_pkg::reg_rsp_t exp, input bit with_data);
    if (got.ready !== exp.ready || got.error !== exp.error ||
        (with_data && got.rdata !== exp.rdata)) begin
      errors++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_intr(input string name, input harness_pkg::intr_vec_t got,
                            input harness_pkg::intr_vec_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_ack(input string name, input harness_pkg::pwr_switch_t got,
                           input harness_pkg::pwr_switch_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // One register transfer with the response sampled at the falling edge
  task automatic reg_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, input harness_pkg::reg_rsp_t exp,
                            input bit with_data);
    int n;
    n = 0;
    @(posedge clk_i);
    #2;
    reg_req = '{valid: 1'b1, write: wr, addr: addr, wdata: wdata, wstrb: strb};
    @(negedge clk_i);
    while (reg_rsp.ready !== 1'b1 && n < WAIT_MAX) begin
      @(negedge clk_i);
      n++;
    end
    if (reg_rsp.ready !== 1'b1) begin
      errors++;
      $display("Register bus gave no ready within %0d cycles", WAIT_MAX);
    end
    check_rsp($sformatf("reg_rsp_o @%h", addr), reg_rsp, exp, with_data);
    @(posedge clk_i);
    #2;
    reg_req = '0;
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [31:0] exp_data);
    reg_access(1'b0, addr, '0, '0, rsp_ok(exp_data), 1'b1);
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    reg_access(1'b1, addr, data, strb, rsp_ok('0), 1'b0);
  endtask

  task automatic wait_intr(input harness_pkg::intr_vec_t exp);
    int n;
    n = 0;
    @(negedge clk_i);
    while (intr !== exp && n < WAIT_MAX) begin
      @(negedge clk_i);
      n++;
    end
    if (intr !== exp) begin
      errors++;
      $display("Interrupt vector did not reach %h within %0d cycles", exp, WAIT_MAX);
    end
  endtask

  task automatic end_test(input string name, input int e0);
    if (errors == e0) begin
      tests_ok++;
      $display("Test %s: ok", name);
    end else begin
      tests_bad++;
      $display("Test %s: %0d errors", name, errors - e0);
    end
  endtask

  task automatic reset_values();
    int e0;
    e0 = errors;
    for (int s = 0; s < NP; s++) begin
      read_check(slot_addr(s, harness_pkg::CNT_COUNT_OFFSET), '0);
      read_check(slot_addr(s, harness_pkg::CNT_THRESH_OFFSET), harness_pkg::CNT_THRESH_RESET);
      read_check(slot_addr(s, harness_pkg::CNT_STATUS_OFFSET), '0);
    end
    @(negedge clk_i);
    check_intr("intr_o", intr, '0);
    check_ack("pwr_switch_ack_n_o", ack_n, '1);
    end_test("reset_state", e0);
  endtask

  task automatic register_rw();
    int          e0;
    int          slot;
    logic [31:0] r;
    logic [31:0] data;
    e0 = errors;
    repeat (20) begin
      r    = lcg_next();
      data = lcg_next();
      slot = int'(r[0]);
      write_reg(slot_addr(slot, harness_pkg::CNT_THRESH_OFFSET), data, r[7:4]);
      for (int b = 0; b < 4; b++) begin
        if (r[4+b]) begin
          mdl_thresh[slot][8*b +: 8] = data[8*b +: 8];
        end
      end
      read_check(slot_addr(slot, harness_pkg::CNT_THRESH_OFFSET), mdl_thresh[slot]);
    end
    // Offsets past the status register
    repeat (8) begin
      r = lcg_next();
      read_check(slot_addr(int'(r[0]), 32'hC + (lcg_next() % 1021) * 4), '0);
    end
    end_test("register_access", e0);
  endtask

  task automatic unmapped_access();
    int                    e0;
    logic [31:0]           r;
    logic [31:0]           addr;
    harness_pkg::reg_rsp_t err_rsp;
    e0      = errors;
    err_rsp = '{ready: 1'b1, error: 1'b1, rdata: '0};
    repeat (20) begin
      r    = lcg_next();
      addr = lcg_next();
      // Aim at the threshold offset so a leaked write would show
      addr = (addr & ~(harness_pkg::PERIPH_SLOT_SIZE - 1)) | harness_pkg::CNT_THRESH_OFFSET;
      if (addr >= harness_pkg::PERIPH_BASE &&
          addr < harness_pkg::PERIPH_BASE + 2 * harness_pkg::PERIPH_SLOT_SIZE) begin
        addr = addr ^ 32'h8000_0000;
      end
      reg_access(r[0], addr, lcg_next(), r[7:4] | 4'h1, err_rsp, 1'b1);
    end
    for (int s = 0; s < NP; s++) begin
      read_check(slot_addr(s, harness_pkg::CNT_THRESH_OFFSET), mdl_thresh[s]);
      read_check(slot_addr(s, harness_pkg::CNT_COUNT_OFFSET), mdl_count[s]);
    end
    end_test("unmapped_access", e0);
  endtask

  task automatic edge_interrupts();
    int          e0;
    int          hold[NP];
    logic [31:0] r;
    e0 = errors;
    for (int s = 0; s < NP; s++) begin
      mdl_thresh[s] = 32'd3 + lcg_next() % 4;
      write_reg(slot_addr(s, harness_pkg::CNT_THRESH_OFFSET), mdl_thresh[s], 4'hF);
      hold[s] = 0;
    end
    // Each level held 2 to 4 cycles
    repeat (150) begin
      @(posedge clk_i);
      #2;
      for (int s = 0; s < NP; s++) begin
        if (hold[s] == 0) begin
          r = lcg_next();
          if (r[0] && !gpio[s]) begin
            model_rise(s);
          end
          gpio[s] = r[0];
          hold[s] = 2 + int'(r[9:8]) % 3;
        end
        hold[s]--;
      end
    end
    repeat (4) @(posedge clk_i);
    #2;
    gpio = '0;
    wait_intr(mdl_flag);
    check_intr("intr_o", intr, mdl_flag);
    for (int s = 0; s < NP; s++) begin
      read_check(slot_addr(s, harness_pkg::CNT_COUNT_OFFSET), mdl_count[s]);
      read_check(slot_addr(s, harness_pkg::CNT_STATUS_OFFSET), {31'b0, mdl_flag[s]});
      write_reg(slot_addr(s, harness_pkg::CNT_STATUS_OFFSET), 32'h1, 4'h1);
      mdl_flag[s] = 1'b0;
    end
    @(negedge clk_i);
    check_intr("intr_o", intr, mdl_flag);
    end_test("edge_count_intr", e0);
  endtask

  task automatic switch_latency();
    int                       e0;
    logic [31:0]              r;
    harness_pkg::pwr_switch_t exp;
    e0 = errors;
    sw_hist.delete();
    repeat (harness_pkg::SWITCH_ACK_LATENCY) sw_hist.push_back(sw_n);
    repeat (60) begin
      @(posedge clk_i);
      #2;
      r    = lcg_next();
      sw_n = r[4:0];
      sw_hist.push_back(sw_n);
      @(negedge clk_i);
      exp = sw_hist.pop_front();
      check_ack("pwr_switch_ack_n_o", ack_n, exp);
    end
    end_test("switch_ack", e0);
  endtask

  initial begin
    clk_i     = 1'b0;
    rst_i     = 1'b1;
    reg_req   = '0;
    gpio      = '0;
    // Requests on during reset, only reset keeps the acknowledges high
    sw_n      = '0;
    lcg_state = 32'hb6a3;
    errors    = 0;
    tests_ok  = 0;
    tests_bad = 0;
    mdl_flag  = '0;
    for (int s = 0; s < NP; s++) begin
      mdl_count[s]  = '0;
      mdl_thresh[s] = harness_pkg::CNT_THRESH_RESET;
    end
    repeat (16) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    sw_n  = '1;
    reset_values();
    register_rw();
    unmapped_access();
    edge_interrupts();
    switch_latency();
    $display("Tests ok: %0d, with errors: %0d, total errors: %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/testharness_assert.sv
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the register demux and the switch acknowledge
// delay line, with the bind statements that attach them
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module testharness_assert (
  input logic                                                  clk_i,
  input logic                                                  rst_i,
  input logic                                                  bus_en_i,
  input logic                                                  ack_en_i,
  input harness_pkg::reg_req_t                                 req_i,
  input harness_pkg::reg_rsp_t                                 rsp_i,
  input harness_pkg::reg_req_t [harness_pkg::EXT_NPERIPH-1:0] slot_req_i,
  input logic [harness_pkg::DATA_W-1:0]                        err_cnt_i,
  input harness_pkg::pwr_switch_t                              ack_n_i
);

  logic [harness_pkg::EXT_NPERIPH-1:0] slot_valid;

  always_comb begin
    for (int i = 0; i < harness_pkg::EXT_NPERIPH; i++) begin
      slot_valid[i] = slot_req_i[i].valid;
    end
  end

  ready_on_valid: assert property (@(posedge clk_i) disable iff (rst_i || !bus_en_i)
    req_i.valid |-> rsp_i.ready)
    else $error("register bus valid without ready");

  one_slot_valid: assert property (@(posedge clk_i) disable iff (rst_i || !bus_en_i)
    $onehot0(slot_valid))
    else $error("more than one slot sees valid");

  // Error counter tracks every error response
  err_count_step: assert property (@(posedge clk_i) disable iff (rst_i || !bus_en_i)
    (req_i.valid && rsp_i.error) |=> (err_cnt_i == $past(err_cnt_i) + 1'b1))
    else $error("error response count did not advance");

  ack_off_after_reset: assert property (@(posedge clk_i)
    (ack_en_i && $fell(rst_i)) |-> (ack_n_i == '1) [*harness_pkg::SWITCH_ACK_LATENCY])
    else $error("switch acknowledge left all ones too early after reset");

endmodule

bind periph_reg_demux testharness_assert demux_assert_i (
  .clk_i,
  .rst_i,
  .bus_en_i  (1'b1),
  .ack_en_i  (1'b0),
  .req_i,
  .rsp_i     (rsp_o),
  .slot_req_i(slot_req_o),
  .err_cnt_i (err_cnt_q),
  .ack_n_i   ('1)
);

bind pwr_switch_ack_delay testharness_assert ack_assert_i (
  .clk_i,
  .rst_i,
  .bus_en_i  (1'b0),
  .ack_en_i  (1'b1),
  .req_i     ('0),
  .rsp_i     ('0),
  .slot_req_i('0),
  .err_cnt_i ('0),
  .ack_n_i   (ack_n_o)
);

`default_nettype wire

//--- flist.f
verilog/harness_pkg.sv
verilog/periph_addr_decode.sv
verilog/periph_reg_demux.sv
verilog/gpio_edge_counter.sv
verilog/pwr_switch_ack_delay.sv
verilog/testharness_top.sv
dv/testharness_assert.sv
dv/tb_testharness.sv

//--- verilog/gpio_edge_counter.sv
//////////////////////////////////////////////////////////////////////
// GPIO rising edge counter with a register-mapped threshold and a
// sticky threshold interrupt
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module gpio_edge_counter (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  gpio_i,
  input  harness_pkg::reg_req_t reg_req_i,
  output harness_pkg::reg_rsp_t reg_rsp_o,
  output logic                  intr_o
);

  logic                           gpio_sync_q;
  logic                           gpio_prev_q;
  logic                           rise;
  logic                           wr_en;
  logic                           thresh_hit;
  logic [harness_pkg::ADDR_W-1:0] offset;
  logic [harness_pkg::DATA_W-1:0] count_q;
  logic [harness_pkg::DATA_W-1:0] count_inc;
  logic [harness_pkg::DATA_W-1:0] thresh_q;
  logic                           flag_q;

  assign offset     = reg_req_i.addr & (harness_pkg::PERIPH_SLOT_SIZE - 1);
  assign wr_en      = reg_req_i.valid & reg_req_i.write;
  assign rise       = gpio_sync_q & ~gpio_prev_q;
  assign count_inc  = count_q + 1'b1;
  assign thresh_hit = rise && (count_inc == thresh_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpio_sync_q <= 1'b0;
      gpio_prev_q <= 1'b0;
      count_q     <= '0;
      thresh_q    <= harness_pkg::CNT_THRESH_RESET;
      flag_q      <= 1'b0;
    end else begin
      gpio_sync_q <= gpio_i;
      gpio_prev_q <= gpio_sync_q;
      if (rise) begin
        count_q <= thresh_hit ? '0 : count_inc;
      end
      if (wr_en && (offset == harness_pkg::CNT_THRESH_OFFSET)) begin
        for (int b = 0; b < harness_pkg::STRB_W; b++) begin
          if (reg_req_i.wstrb[b]) begin
            thresh_q[8*b +: 8] <= reg_req_i.wdata[8*b +: 8];
          end
        end
      end
      // Write one to clear, a new hit in the same cycle wins
      if (wr_en && (offset == harness_pkg::CNT_STATUS_OFFSET) &&
          reg_req_i.wstrb[0] && reg_req_i.wdata[0]) begin
        flag_q <= 1'b0;
      end
      if (thresh_hit) begin
        flag_q <= 1'b1;
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    case (offset)
      harness_pkg::CNT_COUNT_OFFSET:  reg_rsp_o.rdata = count_q;
      harness_pkg::CNT_THRESH_OFFSET: reg_rsp_o.rdata = thresh_q;
      harness_pkg::CNT_STATUS_OFFSET: reg_rsp_o.rdata = {{(harness_pkg::DATA_W-1){1'b0}}, flag_q};
      default:                        reg_rsp_o.rdata = '0;
    endcase
  end

  assign intr_o = flag_q;

endmodule

`default_nettype wire

//--- verilog/harness_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared widths, peripheral address map, register offsets and the
// register bus, power switch and interrupt types of the harness
//////////////////////////////////////////////////////////////////////
`default_nettype none

package harness_pkg;

  // Register bus
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  // External peripheral window
  localparam int unsigned EXT_NPERIPH = 2;
  localparam int unsigned SLOT_IDX_W = 1;
  localparam logic [ADDR_W-1:0] PERIPH_BASE = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] PERIPH_SLOT_SIZE = 32'h0000_1000;

  typedef struct packed {
    logic [SLOT_IDX_W-1:0] idx;
    logic [ADDR_W-1:0]     start_addr;
    logic [ADDR_W-1:0]     end_addr;
  } periph_rule_t;

  // End address is exclusive
  localparam periph_rule_t PERIPH_ADDR_RULES[EXT_NPERIPH] = '{
    '{idx: 1'd0, start_addr: PERIPH_BASE, end_addr: PERIPH_BASE + PERIPH_SLOT_SIZE},
    '{idx: 1'd1, start_addr: PERIPH_BASE + PERIPH_SLOT_SIZE,
      end_addr: PERIPH_BASE + 32'd2 * PERIPH_SLOT_SIZE}
  };

  // Edge counter registers
  localparam logic [ADDR_W-1:0] CNT_COUNT_OFFSET = 32'h0;
  localparam logic [ADDR_W-1:0] CNT_THRESH_OFFSET = 32'h4;
  localparam logic [ADDR_W-1:0] CNT_STATUS_OFFSET = 32'h8;
  localparam logic [DATA_W-1:0] CNT_THRESH_RESET = 32'd2048;

  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } reg_req_t;

  typedef struct packed {
    logic              ready;
    logic              error;
    logic [DATA_W-1:0] rdata;
  } reg_rsp_t;

  // Power domains, all switch bits active low
  localparam int unsigned NUM_BANKS = 2;
  localparam int unsigned EXT_DOMAINS = 1;
  localparam int unsigned SWITCH_ACK_LATENCY = 15;

  typedef struct packed {
    logic                   cpu;
    logic                   periph;
    logic [NUM_BANKS-1:0]   banks;
    logic [EXT_DOMAINS-1:0] ext;
  } pwr_switch_t;

  typedef logic [EXT_NPERIPH-1:0] intr_vec_t;

endpackage

`default_nettype wire

//--- verilog/periph_addr_decode.sv
//////////////////////////////////////////////////////////////////////
// Address decoder for the external peripheral slots
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module periph_addr_decode (
  input  logic [harness_pkg::ADDR_W-1:0]     addr_i,
  output logic [harness_pkg::SLOT_IDX_W-1:0] idx_o,
  output logic                               hit_o
);

  harness_pkg::periph_rule_t rule;

  // Linear search over the rule table, no default slot
  always_comb begin
    idx_o = '0;
    hit_o = 1'b0;
    rule  = '0;
    for (int i = 0; i < harness_pkg::EXT_NPERIPH; i++) begin
      rule = harness_pkg::PERIPH_ADDR_RULES[i];
      if ((addr_i >= rule.start_addr) && (addr_i < rule.end_addr)) begin
        idx_o = rule.idx;
        hit_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/periph_reg_demux.sv
//////////////////////////////////////////////////////////////////////
// Register bus demultiplexer onto the external peripheral slots,
// with an error response for unmapped addresses
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module periph_reg_demux (
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  input  harness_pkg::reg_req_t                                 req_i,
  output harness_pkg::reg_rsp_t                                 rsp_o,
  output harness_pkg::reg_req_t [harness_pkg::EXT_NPERIPH-1:0] slot_req_o,
  input  harness_pkg::reg_rsp_t [harness_pkg::EXT_NPERIPH-1:0] slot_rsp_i
);

  logic [harness_pkg::SLOT_IDX_W-1:0] sel_idx;
  logic                               sel_hit;
  logic [harness_pkg::DATA_W-1:0]     err_cnt_q;

  periph_addr_decode periph_addr_decode_i (
    .addr_i(req_i.addr),
    .idx_o (sel_idx),
    .hit_o (sel_hit)
  );

  // Only the decoded slot sees valid
  always_comb begin
    for (int i = 0; i < harness_pkg::EXT_NPERIPH; i++) begin
      slot_req_o[i]       = req_i;
      slot_req_o[i].valid = req_i.valid && sel_hit && (int'(sel_idx) == i);
    end
  end

  always_comb begin
    if (sel_hit) begin
      rsp_o = slot_rsp_i[sel_idx];
    end else begin
      // Unmapped, answer in the same cycle
      rsp_o.ready = req_i.valid;
      rsp_o.error = req_i.valid;
      rsp_o.rdata = '0;
    end
  end

  // Count of error responses
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_cnt_q <= '0;
    end else if (req_i.valid && !sel_hit) begin
      err_cnt_q <= err_cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/pwr_switch_ack_delay.sv
//////////////////////////////////////////////////////////////////////
// Fixed latency delay line standing in for power switch cells
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module pwr_switch_ack_delay (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  harness_pkg::pwr_switch_t switch_n_i,
  output harness_pkg::pwr_switch_t ack_n_o
);

  localparam int unsigned LAT = harness_pkg::SWITCH_ACK_LATENCY;

  harness_pkg::pwr_switch_t stage_q[LAT];

  // All ones reads as every domain switched off
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < LAT; i++) begin
        stage_q[i] <= '1;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < LAT; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign ack_n_o = stage_q[LAT-1];

endmodule

`default_nettype wire

//--- verilog/testharness_top.sv
//////////////////////////////////////////////////////////////////////
// Harness top with register demux, edge counters, switch acknowledge
// delay and the external interrupt vector
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module testharness_top (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  harness_pkg::reg_req_t               reg_req_i,
  output harness_pkg::reg_rsp_t               reg_rsp_o,
  input  logic [harness_pkg::EXT_NPERIPH-1:0] gpio_i,
  output harness_pkg::intr_vec_t              intr_o,
  input  harness_pkg::pwr_switch_t            pwr_switch_n_i,
  output harness_pkg::pwr_switch_t            pwr_switch_ack_n_o
);

  harness_pkg::reg_req_t [harness_pkg::EXT_NPERIPH-1:0] slot_req;
  harness_pkg::reg_rsp_t [harness_pkg::EXT_NPERIPH-1:0] slot_rsp;
  logic [harness_pkg::EXT_NPERIPH-1:0]                  cnt_intr;

  periph_reg_demux periph_reg_demux_i (
    .clk_i,
    .rst_i,
    .req_i     (reg_req_i),
    .rsp_o     (reg_rsp_o),
    .slot_req_o(slot_req),
    .slot_rsp_i(slot_rsp)
  );

  // One counter per slot, slot i on gpio bit i
  for (genvar i = 0; i < harness_pkg::EXT_NPERIPH; i++) begin : gen_cnt
    gpio_edge_counter gpio_edge_counter_i (
      .clk_i,
      .rst_i,
      .gpio_i   (gpio_i[i]),
      .reg_req_i(slot_req[i]),
      .reg_rsp_o(slot_rsp[i]),
      .intr_o   (cnt_intr[i])
    );
  end

  pwr_switch_ack_delay pwr_switch_ack_delay_i (
    .clk_i,
    .rst_i,
    .switch_n_i(pwr_switch_n_i),
    .ack_n_o   (pwr_switch_ack_n_o)
  );

  // Unused lines stay low
  always_comb begin
    intr_o = '0;
    for (int i = 0; i < harness_pkg::EXT_NPERIPH; i++) begin
      intr_o[i] = cnt_intr[i];
    end
  end

endmodule

`default_nettype wire
